// ==== include/rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// sizing of the reservation station and its buses

`define RS_ENTRIES    8    // station depth
`define TAG_WIDTH     6    // physical register tag
`define DATA_WIDTH    32   // operand and result word
`define UOP_WIDTH     16   // opaque micro-op payload

`define NUM_BUSES     3    // alu, mul, load
`define ISSUE_CREDITS 2    // granted by execution side after reset

`endif

// ==== hdl/rsPkg.sv ====
`default_nettype none

`include "rs_defines.svh"

package rsPkg;

    typedef logic [`TAG_WIDTH-1:0]  tagT;   // physical register tag
    typedef logic [`DATA_WIDTH-1:0] dataT;
    typedef logic [`UOP_WIDTH-1:0]  uopT;   // opaque to the station

    // index into the entry table
    typedef logic [$clog2(`RS_ENTRIES)-1:0] entryIdxT;

    // must hold the full grant, so one more than the count
    typedef logic [$clog2(`ISSUE_CREDITS+1)-1:0] creditT;

endpackage

`default_nettype wire

// ==== hdl/operandSnoop.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module operandSnoop
    import rsPkg::*;
(
    input  tagT  waitTag,
    input  logic resultValid [`NUM_BUSES],
    input  tagT  resultTag   [`NUM_BUSES],
    input  dataT resultData  [`NUM_BUSES],
    output logic hit,
    output dataT hitData
);

    always_comb begin
        hit     = 1'b0;
        hitData = '0;
        // walk down so the lowest matching bus wins
        for (int b = `NUM_BUSES - 1; b >= 0; b--) begin
            if (resultValid[b] && (resultTag[b] == waitTag)) begin
                hit     = 1'b1;
                hitData = resultData[b];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lowestFirstSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module lowestFirstSelect
    import rsPkg::*;
#(
    parameter int WIDTH = `RS_ENTRIES
) (
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output entryIdxT         grantIdx,
    output logic             anyGrant
);

    assign grant    = request & (~request + WIDTH'(1));   // isolate lowest set bit
    assign anyGrant = |request;

    always_comb begin
        grantIdx = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (grant[i]) begin
                grantIdx = grantIdx | entryIdxT'(i);
            end
        end
    end

    // grant must stay one-hot, inside the request, and agree with the index
    always_comb begin
        assert ($onehot0(grant) && ((grant & request) == grant)
                && (!anyGrant || grant[grantIdx]))
            else $error("lowestFirstSelect: bad grant %b for request %b", grant, request);
    end

endmodule

`default_nettype wire

// ==== hdl/issueCreditCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module issueCreditCounter
    import rsPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic issueFire,
    input  logic creditReturn,
    output logic creditAvail
);

    creditT creditCnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            creditCnt <= creditT'(`ISSUE_CREDITS);
        end else begin
            case ({issueFire, creditReturn})
                2'b10:   creditCnt <= creditCnt - creditT'(1);
                2'b01:   creditCnt <= creditCnt + creditT'(1);
                default: creditCnt <= creditCnt;   // both or neither
            endcase
        end
    end

    assign creditAvail = (creditCnt != '0);

    // execution side never returns more than it was granted
    assert property (@(posedge clk) disable iff (reset)
        creditReturn && !issueFire |-> creditCnt != creditT'(`ISSUE_CREDITS))
        else $error("issueCreditCounter: credit return beyond grant");

    // the top level must hold issue while out of credit
    assert property (@(posedge clk) disable iff (reset)
        issueFire |-> creditCnt != '0)
        else $error("issueCreditCounter: issue with no credit");

endmodule

`default_nettype wire

// ==== hdl/rsEntryArray.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module rsEntryArray
    import rsPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   dispatchValid,
    input  uopT                    dispatchUop,
    input  tagT                    dispatchDest,
    input  tagT                    src1Tag,
    input  logic                   src1Ready,
    input  dataT                   src1Data,
    input  tagT                    src2Tag,
    input  logic                   src2Ready,
    input  dataT                   src2Data,

    input  logic                   resultValid [`NUM_BUSES],
    input  tagT                    resultTag   [`NUM_BUSES],
    input  dataT                   resultData  [`NUM_BUSES],

    input  logic [`RS_ENTRIES-1:0] issueGrant,
    input  logic                   issueFire,
    input  entryIdxT               grantIdx,

    output logic [`RS_ENTRIES-1:0] readyVec,
    output uopT                    selUop,
    output tagT                    selDest,
    output dataT                   selOp1,
    output dataT                   selOp2
);

    logic [`RS_ENTRIES-1:0] busy;
    logic [`RS_ENTRIES-1:0] pres1;
    logic [`RS_ENTRIES-1:0] pres2;
    uopT                    uopQ  [`RS_ENTRIES];
    tagT                    destQ [`RS_ENTRIES];
    tagT                    tag1Q [`RS_ENTRIES];
    tagT                    tag2Q [`RS_ENTRIES];
    dataT                   op1Q  [`RS_ENTRIES];
    dataT                   op2Q  [`RS_ENTRIES];

    logic [`RS_ENTRIES-1:0] wake1Hit;
    logic [`RS_ENTRIES-1:0] wake2Hit;
    dataT                   wake1Data [`RS_ENTRIES];
    dataT                   wake2Data [`RS_ENTRIES];
    logic [`RS_ENTRIES-1:0] fill1;
    logic [`RS_ENTRIES-1:0] fill2;

    logic                   disp1Hit;
    logic                   disp2Hit;
    dataT                   disp1BusData;
    dataT                   disp2BusData;
    logic                   disp1Present;
    logic                   disp2Present;
    dataT                   disp1Data;
    dataT                   disp2Data;

    entryIdxT               allocIdx;
    logic                   haveFree;
    logic                   allocate;

    // bypass from the buses during the dispatch cycle
    operandSnoop dispSnoop1 (
        .waitTag    (src1Tag),
        .resultValid(resultValid),
        .resultTag  (resultTag),
        .resultData (resultData),
        .hit        (disp1Hit),
        .hitData    (disp1BusData)
    );

    operandSnoop dispSnoop2 (
        .waitTag    (src2Tag),
        .resultValid(resultValid),
        .resultTag  (resultTag),
        .resultData (resultData),
        .hit        (disp2Hit),
        .hitData    (disp2BusData)
    );

    assign disp1Present = src1Ready | disp1Hit;
    assign disp2Present = src2Ready | disp2Hit;
    assign disp1Data    = src1Ready ? src1Data : disp1BusData;   // supplied data wins
    assign disp2Data    = src2Ready ? src2Data : disp2BusData;

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : gWake
        operandSnoop wakeSnoop1 (
            .waitTag    (tag1Q[i]),
            .resultValid(resultValid),
            .resultTag  (resultTag),
            .resultData (resultData),
            .hit        (wake1Hit[i]),
            .hitData    (wake1Data[i])
        );

        operandSnoop wakeSnoop2 (
            .waitTag    (tag2Q[i]),
            .resultValid(resultValid),
            .resultTag  (resultTag),
            .resultData (resultData),
            .hit        (wake2Hit[i]),
            .hitData    (wake2Data[i])
        );
    end

    assign fill1 = busy & ~pres1 & wake1Hit;   // only waiting operands capture
    assign fill2 = busy & ~pres2 & wake2Hit;

    always_comb begin
        allocIdx = '0;
        haveFree = 1'b0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                allocIdx = entryIdxT'(i);
                haveFree = 1'b1;
            end
        end
    end

    assign allocate = dispatchValid & haveFree;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            pres1 <= '0;
            pres2 <= '0;
        end else begin
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (issueFire && issueGrant[i]) begin
                    busy[i] <= 1'b0;
                end
                if (fill1[i]) begin
                    pres1[i] <= 1'b1;
                end
                if (fill2[i]) begin
                    pres2[i] <= 1'b1;
                end
                if (allocate && (allocIdx == entryIdxT'(i))) begin   // free entry, no clash
                    busy[i]  <= 1'b1;
                    pres1[i] <= disp1Present;
                    pres2[i] <= disp2Present;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (fill1[i]) begin
                op1Q[i] <= wake1Data[i];
            end
            if (fill2[i]) begin
                op2Q[i] <= wake2Data[i];
            end
            if (allocate && (allocIdx == entryIdxT'(i))) begin
                uopQ[i]  <= dispatchUop;
                destQ[i] <= dispatchDest;
                tag1Q[i] <= src1Tag;
                tag2Q[i] <= src2Tag;
                op1Q[i]  <= disp1Data;
                op2Q[i]  <= disp2Data;
            end
        end
    end

    assign readyVec = busy & pres1 & pres2;

    assign selUop  = uopQ[grantIdx];
    assign selDest = destQ[grantIdx];
    assign selOp1  = op1Q[grantIdx];
    assign selOp2  = op2Q[grantIdx];

    // upstream credit must keep dispatch away from a full table
    assert property (@(posedge clk) disable iff (reset)
        dispatchValid |-> haveFree)
        else $error("rsEntryArray: dispatch while all entries busy");

endmodule

`default_nettype wire

// ==== hdl/reservationStation.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module reservationStation
    import rsPkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic dispatchValid,
    input  uopT  dispatchUop,
    input  tagT  dispatchDest,
    input  tagT  src1Tag,
    input  logic src1Ready,
    input  dataT src1Data,
    input  tagT  src2Tag,
    input  logic src2Ready,
    input  dataT src2Data,
    output logic dispatchCredit,

    input  logic resultValid [`NUM_BUSES],
    input  tagT  resultTag   [`NUM_BUSES],
    input  dataT resultData  [`NUM_BUSES],

    output logic issueValid,
    output uopT  issueUop,
    output tagT  issueDest,
    output dataT issueOp1,
    output dataT issueOp2,
    input  logic issueCreditReturn
);

    logic [`RS_ENTRIES-1:0] readyVec;
    logic [`RS_ENTRIES-1:0] grant;
    entryIdxT               grantIdx;
    logic                   anyGrant;
    logic                   creditAvail;
    logic                   issueFire;
    uopT                    selUop;
    tagT                    selDest;
    dataT                   selOp1;
    dataT                   selOp2;

    rsEntryArray entries (
        .clk          (clk),
        .reset        (reset),
        .dispatchValid(dispatchValid),
        .dispatchUop  (dispatchUop),
        .dispatchDest (dispatchDest),
        .src1Tag      (src1Tag),
        .src1Ready    (src1Ready),
        .src1Data     (src1Data),
        .src2Tag      (src2Tag),
        .src2Ready    (src2Ready),
        .src2Data     (src2Data),
        .resultValid  (resultValid),
        .resultTag    (resultTag),
        .resultData   (resultData),
        .issueGrant   (grant),
        .issueFire    (issueFire),
        .grantIdx     (grantIdx),
        .readyVec     (readyVec),
        .selUop       (selUop),
        .selDest      (selDest),
        .selOp1       (selOp1),
        .selOp2       (selOp2)
    );

    lowestFirstSelect #(
        .WIDTH(`RS_ENTRIES)
    ) select (
        .request (readyVec),
        .grant   (grant),
        .grantIdx(grantIdx),
        .anyGrant(anyGrant)
    );

    issueCreditCounter credits (
        .clk         (clk),
        .reset       (reset),
        .issueFire   (issueFire),
        .creditReturn(issueCreditReturn),
        .creditAvail (creditAvail)
    );

    assign issueFire = anyGrant & creditAvail;   // ready entries wait without credit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid     <= 1'b0;
            dispatchCredit <= 1'b0;
        end else begin
            issueValid     <= issueFire;
            dispatchCredit <= issueFire;   // one entry freed per issue
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            issueUop  <= selUop;
            issueDest <= selDest;
            issueOp1  <= selOp1;
            issueOp2  <= selOp2;
        end
    end

endmodule

`default_nettype wire

// ==== tests/reservationStationTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module reservationStationTb
    import rsPkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TAGS     = 2**`TAG_WIDTH;
    // cycle budget per test, reset through accounting
    localparam int TEST_CYCLES  = RESET_CYCLES + 4 + 20 + 30 + 30 + 30 + 60;
    localparam int MARGIN_NS    = 100 * CLK_PERIOD;

    logic clk = 1'b0;
    logic reset;
    logic dispatchValid;
    uopT  dispatchUop;
    tagT  dispatchDest;
    tagT  src1Tag;
    logic src1Ready;
    dataT src1Data;
    tagT  src2Tag;
    logic src2Ready;
    dataT src2Data;
    logic dispatchCredit;
    logic resultValid [`NUM_BUSES];
    tagT  resultTag   [`NUM_BUSES];
    dataT resultData  [`NUM_BUSES];
    logic issueValid;
    uopT  issueUop;
    tagT  issueDest;
    dataT issueOp1;
    dataT issueOp2;
    logic issueCreditReturn;

    // scoreboard, keyed by destination tag
    logic pending [NUM_TAGS];
    logic wait1   [NUM_TAGS];
    logic wait2   [NUM_TAGS];
    tagT  tag1E   [NUM_TAGS];
    tagT  tag2E   [NUM_TAGS];
    uopT  uopE    [NUM_TAGS];
    dataT op1E    [NUM_TAGS];
    dataT op2E    [NUM_TAGS];
    logic fastE   [NUM_TAGS];
    int   dispCycle [NUM_TAGS];
    tagT  dispOrder[$];
    tagT  issueOrder[$];
    int   issueCycles[$];

    int   seed;
    int   errors = 0;
    int   testStartErrors = 0;
    int   testNum = 0;
    int   cycleCnt = 0;
    int   dispatches = 0;
    int   issuesSeen = 0;
    int   creditPulses = 0;
    int   returned = 0;
    int   owed = 0;          // credits held back from the station
    int   dispCredits = 0;
    int   pendingCount = 0;
    int   nextDest = 0;
    int   startIssues;
    logic autoReturn = 1'b1;

    reservationStation reservationStation_inst (
        .clk              (clk),
        .reset            (reset),
        .dispatchValid    (dispatchValid),
        .dispatchUop      (dispatchUop),
        .dispatchDest     (dispatchDest),
        .src1Tag          (src1Tag),
        .src1Ready        (src1Ready),
        .src1Data         (src1Data),
        .src2Tag          (src2Tag),
        .src2Ready        (src2Ready),
        .src2Data         (src2Data),
        .dispatchCredit   (dispatchCredit),
        .resultValid      (resultValid),
        .resultTag        (resultTag),
        .resultData       (resultData),
        .issueValid       (issueValid),
        .issueUop         (issueUop),
        .issueDest        (issueDest),
        .issueOp1         (issueOp1),
        .issueOp2         (issueOp2),
        .issueCreditReturn(issueCreditReturn)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycleCnt++;

    task automatic logError(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finishTest(input string name);
        testNum++;
        $display("test %0d %s: %0d errors", testNum, name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    // next cycle, inputs back to idle, credit returned for the issue just seen
    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
        dispatchValid = 1'b0;
        for (int b = 0; b < `NUM_BUSES; b++) begin
            resultValid[b] = 1'b0;
        end
        issueCreditReturn = 1'b0;
        if (issueValid) owed++;
        if (autoReturn && owed > 0) begin
            issueCreditReturn = 1'b1;
            owed--;
            returned++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic waitDrain();
        while (pendingCount != 0) begin
            tick();
        end
    endtask

    task automatic dispatch(input logic r1, input tagT t1, input logic r2, input tagT t2,
                            input logic fast);
        tagT d;
        tick();
        while (dispCredits == 0) begin
            tick();
        end
        d = tagT'(nextDest);
        nextDest = (nextDest + 1) % 40;   // dests stay below the wait tags
        dispCredits--;
        dispatches++;
        dispatchValid = 1'b1;
        dispatchUop   = uopT'($random(seed));
        dispatchDest  = d;
        src1Tag       = t1;
        src1Ready     = r1;
        src1Data      = dataT'($random(seed));
        src2Tag       = t2;
        src2Ready     = r2;
        src2Data      = dataT'($random(seed));
        pending[d]    = 1'b1;
        pendingCount++;
        uopE[d]       = dispatchUop;
        wait1[d]      = !r1;
        wait2[d]      = !r2;
        tag1E[d]      = t1;
        tag2E[d]      = t2;
        op1E[d]       = r1 ? src1Data : '0;
        op2E[d]       = r2 ? src2Data : '0;
        fastE[d]      = fast;
        dispCycle[d]  = cycleCnt;
        dispOrder.push_back(d);
    endtask

    // drives one bus in the current cycle and wakes the matching waiters
    task automatic broadcast(input int bus, input tagT t);
        dataT v;
        v = dataT'($random(seed));
        resultValid[bus] = 1'b1;
        resultTag[bus]   = t;
        resultData[bus]  = v;
        for (int k = 0; k < NUM_TAGS; k++) begin
            if (pending[k] && wait1[k] && tag1E[k] == t) begin
                wait1[k] = 1'b0;
                op1E[k]  = v;
            end
            if (pending[k] && wait2[k] && tag2E[k] == t) begin
                wait2[k] = 1'b0;
                op2E[k]  = v;
            end
        end
    endtask

    task automatic checkIssue();
        tagT d;
        d = issueDest;
        issuesSeen++;
        assert (issuesSeen - (returned - int'(issueCreditReturn)) <= `ISSUE_CREDITS)
            else logError("issue beyond the granted credits");
        assert (pending[d]) else logError($sformatf("dest %0d issued but not pending", d));
        if (pending[d]) begin
            assert (!wait1[d] && !wait2[d])
                else logError($sformatf("dest %0d issued before its broadcast", d));
            assert (issueUop == uopE[d])
                else logError($sformatf("dest %0d uop %h, expected %h", d, issueUop, uopE[d]));
            assert (issueOp1 == op1E[d] && issueOp2 == op2E[d])
                else logError($sformatf("dest %0d operands %h %h, expected %h %h",
                                        d, issueOp1, issueOp2, op1E[d], op2E[d]));
            if (fastE[d]) begin
                assert (cycleCnt - dispCycle[d] == 2)
                    else logError($sformatf("dest %0d issued after %0d edges, expected 2",
                                            d, cycleCnt - dispCycle[d]));
            end
            pending[d] = 1'b0;
            pendingCount--;
        end
        issueOrder.push_back(d);
        issueCycles.push_back(cycleCnt);
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (dispatchCredit) begin
                creditPulses++;
                dispCredits++;
                assert (dispCredits <= `RS_ENTRIES)
                    else logError("dispatch credits above table size");
            end
            if (issueValid) checkIssue();
        end
    end

    assert property (@(posedge clk) reset |-> !issueValid && !dispatchCredit)
        else logError("issue or credit output high during reset");

    assert property (@(posedge clk) $fell(reset) |=> !issueValid && !dispatchCredit)
        else logError("issue or credit output high right after reset");

    assert property (@(posedge clk) disable iff (reset) dispatchCredit == issueValid)
        else logError("dispatch credit pulse does not match the issue");

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("timeout: tests did not finish in %0d ns", TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed              = 80702;
        reset             = 1'b1;
        dispatchValid     = 1'b0;
        dispatchUop       = '0;
        dispatchDest      = '0;
        src1Tag           = '0;
        src1Ready         = 1'b0;
        src1Data          = '0;
        src2Tag           = '0;
        src2Ready         = 1'b0;
        src2Data          = '0;
        issueCreditReturn = 1'b0;
        for (int b = 0; b < `NUM_BUSES; b++) begin
            resultValid[b] = 1'b0;
            resultTag[b]   = '0;
            resultData[b]  = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset       = 1'b0;
        dispCredits = `RS_ENTRIES;

        idle(4);
        finishTest("reset");

        repeat (4) begin
            dispatch(1'b1, tagT'(0), 1'b1, tagT'(0), 1'b1);
            waitDrain();
        end
        finishTest("ready dispatch");

        dispatch(1'b0, tagT'(40), 1'b1, tagT'(0), 1'b0);
        idle(3);
        broadcast(1, tagT'(40));
        waitDrain();
        dispatch(1'b1, tagT'(0), 1'b0, tagT'(41), 1'b0);
        broadcast(2, tagT'(41));          // same cycle as dispatch
        waitDrain();
        dispatch(1'b0, tagT'(42), 1'b0, tagT'(43), 1'b0);
        idle(2);
        broadcast(0, tagT'(43));
        broadcast(1, tagT'(42));
        waitDrain();
        finishTest("wakeup and bypass");

        dispOrder.delete();
        issueOrder.delete();
        issueCycles.delete();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            dispatch(1'b0, tagT'(50), 1'b1, tagT'(0), 1'b0);
        end
        idle(2);
        broadcast(0, tagT'(50));
        waitDrain();
        assert (issueOrder.size() == `RS_ENTRIES) else logError("ordering test lost an issue");
        for (int i = 0; i < issueOrder.size() && i < dispOrder.size(); i++) begin
            assert (issueOrder[i] == dispOrder[i]
                    && (i == 0 || issueCycles[i] == issueCycles[i-1] + 1))
                else logError($sformatf("entry %0d issued out of order or late", i));
        end
        finishTest("ordering");

        autoReturn  = 1'b0;
        startIssues = issuesSeen;
        for (int i = 0; i < 5; i++) begin
            dispatch(1'b1, tagT'(0), 1'b1, tagT'(0), 1'b0);
        end
        dispatch(1'b0, tagT'(55), 1'b1, tagT'(0), 1'b0);
        idle(2);
        broadcast(2, tagT'(55));          // wakeup while stalled
        idle(8);
        assert (issuesSeen - startIssues <= `ISSUE_CREDITS)
            else logError("issues went past the credits without a return");
        autoReturn = 1'b1;
        waitDrain();
        finishTest("back-pressure");

        for (int i = 0; i < 12; i++) begin
            dispatch(1'($random(seed)), tagT'(60 + i % 2), 1'($random(seed)), tagT'(62), 1'b0);
            if (i % 4 == 3) begin
                broadcast(0, tagT'(60));
                broadcast(1, tagT'(61));
                broadcast(2, tagT'(62));
            end
        end
        tick();
        broadcast(0, tagT'(60));
        broadcast(1, tagT'(61));
        broadcast(2, tagT'(62));
        waitDrain();
        idle(2);
        assert (dispatches == issuesSeen && creditPulses == issuesSeen && pendingCount == 0)
            else logError($sformatf("%0d dispatches, %0d issues, %0d credit pulses",
                                    dispatches, issuesSeen, creditPulses));
        finishTest("accounting");

        $display("%0d tests run, %0d issues, %0d errors", testNum, issuesSeen, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hdl/rsPkg.sv
hdl/operandSnoop.sv
hdl/lowestFirstSelect.sv
hdl/issueCreditCounter.sv
hdl/rsEntryArray.sv
hdl/reservationStation.sv
tests/reservationStationTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := reservationStationTb
FILELIST   := filelist.f
FLAGS      := --timing --assert
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
